// File: cluster_periph_defs.svh
// shared sizes and reset constants of the cluster peripheral block
// NB_CORES is fixed here, and no module takes a core-count parameter
// EVT_WIDTH must stay 4 because the event bit positions are hard-wired
`ifndef CLUSTER_PERIPH_DEFS_SVH
`define CLUSTER_PERIPH_DEFS_SVH

// cluster size
`define NB_CORES        4

// peripheral port
`define DATA_WIDTH      32
`define ADDR_WIDTH      12
`define OFFSET_WIDTH    8

// event sources per core: timer, dma, accelerator, software
`define EVT_WIDTH       4

`define BOOT_ADDR_RESET 32'h1C00_0000

`endif

// File: cluster_periph_pkg.sv
// shared types of the cluster peripheral block
// all widths come from the defs header
`include "cluster_periph_defs.svh"

package cluster_periph_pkg;

  typedef logic [`DATA_WIDTH-1:0]   data_t;
  typedef logic [`NB_CORES-1:0]     core_mask_t;
  typedef logic [`EVT_WIDTH-1:0]    evt_vec_t;
  typedef logic [`OFFSET_WIDTH-1:0] reg_off_t;

  // address bits 11:10
  typedef enum logic [1:0] {
    REGION_CTRL     = 2'd0,
    REGION_TIMER    = 2'd1,
    REGION_EU       = 2'd2,
    REGION_UNMAPPED = 2'd3
  } region_e;

  // word offsets inside the control unit
  typedef enum logic [`OFFSET_WIDTH-1:0] {
    CTRL_EOC       = 8'd0,
    CTRL_FETCH_EN  = 8'd1,
    CTRL_BOOT_ADDR = 8'd2
  } ctrl_reg_e;

  // word offsets inside the timer
  typedef enum logic [`OFFSET_WIDTH-1:0] {
    TIMER_CFG   = 8'd0,
    TIMER_COUNT = 8'd1,
    TIMER_CMP   = 8'd2
  } timer_reg_e;

  // low offset bits inside one event unit core block
  typedef enum logic [1:0] {
    EU_MASK   = 2'd0,
    EU_BUFFER = 2'd1,
    EU_WAIT   = 2'd2,
    EU_SW_EVT = 2'd3
  } eu_reg_e;

  typedef enum logic {
    ST_RUN   = 1'b0,
    ST_SLEEP = 1'b1
  } sleep_state_e;

endpackage

// File: periph_bus_if.sv
// one internal peripheral slave port
// single-cycle request, no grant, read data is combinational from the slave
`timescale 1ns/1ps

interface periph_bus_if;
  import cluster_periph_pkg::*;

  logic     req;
  logic     we;
  reg_off_t offset;
  data_t    wdata;
  data_t    rdata;

  // decoder side
  modport master (output req, we, offset, wdata, input rdata);

  // register block side
  modport slave (input req, we, offset, wdata, output rdata);

endinterface

// File: periph_decoder.sv
// splits the peripheral port into three regions of 256 words each
// read data is registered and comes back one cycle after every request
// region 3 is unmapped: reads return zero and writes are dropped
`timescale 1ns/1ps
`include "cluster_periph_defs.svh"

module periph_decoder (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       req_i,
  input  logic                       we_i,
  input  logic [`ADDR_WIDTH-1:0]     addr_i,
  input  cluster_periph_pkg::data_t  wdata_i,
  output cluster_periph_pkg::data_t  rdata_o,
  output logic                       rvalid_o,
  periph_bus_if.master               ctrl_bus,
  periph_bus_if.master               timer_bus,
  periph_bus_if.master               eu_bus
);
  import cluster_periph_pkg::*;

  region_e  region;
  reg_off_t offset;
  data_t    sel_rdata;
  data_t    rdata_q;
  logic     rvalid_q;

  // byte address, bits 1:0 dropped
  assign region = region_e'(addr_i[11:10]);
  assign offset = addr_i[9:2];

  // request strobe only on the selected slave
  assign ctrl_bus.req  = req_i && (region == REGION_CTRL);
  assign timer_bus.req = req_i && (region == REGION_TIMER);
  assign eu_bus.req    = req_i && (region == REGION_EU);

  assign ctrl_bus.we      = we_i;
  assign ctrl_bus.offset  = offset;
  assign ctrl_bus.wdata   = wdata_i;
  assign timer_bus.we     = we_i;
  assign timer_bus.offset = offset;
  assign timer_bus.wdata  = wdata_i;
  assign eu_bus.we        = we_i;
  assign eu_bus.offset    = offset;
  assign eu_bus.wdata     = wdata_i;

  // response mux, writes answer with zero
  always_comb begin
    sel_rdata = '0;
    if (!we_i) begin
      case (region)
        REGION_CTRL:  sel_rdata = ctrl_bus.rdata;
        REGION_TIMER: sel_rdata = timer_bus.rdata;
        REGION_EU:    sel_rdata = eu_bus.rdata;
        default:      sel_rdata = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= sel_rdata;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule

// File: cluster_ctrl_regs.sv
// end-of-computation, per-core fetch enable and shared boot address
// writes take effect at the end of the request cycle
`timescale 1ns/1ps
`include "cluster_periph_defs.svh"

module cluster_ctrl_regs (
  input  logic                             clk_i,
  input  logic                             reset_i,
  periph_bus_if.slave                      bus,
  output logic                             eoc_o,
  output cluster_periph_pkg::core_mask_t   fetch_en_o,
  output cluster_periph_pkg::data_t        boot_addr_o
);
  import cluster_periph_pkg::*;

  ctrl_reg_e  reg_sel;
  logic       wr_en;
  logic       eoc_q;
  core_mask_t fetch_en_q;
  data_t      boot_addr_q;

  assign reg_sel = ctrl_reg_e'(bus.offset);
  assign wr_en   = bus.req && bus.we;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      eoc_q       <= 1'b0;
      fetch_en_q  <= '0;
      boot_addr_q <= `BOOT_ADDR_RESET;
    end else if (wr_en) begin
      case (reg_sel)
        CTRL_EOC:       eoc_q       <= bus.wdata[0];
        CTRL_FETCH_EN:  fetch_en_q  <= bus.wdata[`NB_CORES-1:0];
        CTRL_BOOT_ADDR: boot_addr_q <= bus.wdata;
        default:        ;
      endcase
    end
  end

  // readback of the stored values, unused offsets read zero
  always_comb begin
    case (reg_sel)
      CTRL_EOC:       bus.rdata = {{(`DATA_WIDTH-1){1'b0}}, eoc_q};
      CTRL_FETCH_EN:  bus.rdata = {{(`DATA_WIDTH-`NB_CORES){1'b0}}, fetch_en_q};
      CTRL_BOOT_ADDR: bus.rdata = boot_addr_q;
      default:        bus.rdata = '0;
    endcase
  end

  assign eoc_o       = eoc_q;
  assign fetch_en_o  = fetch_en_q;
  assign boot_addr_o = boot_addr_q;

endmodule

// File: cluster_timer.sv
// free-running 32-bit counter on clk_i with one compare register
// the event strobe is combinational on count == compare while enabled
// a compare value of zero gives a strobe in every enabled cycle
`timescale 1ns/1ps
`include "cluster_periph_defs.svh"

module cluster_timer (
  input  logic        clk_i,
  input  logic        reset_i,
  periph_bus_if.slave bus,
  output logic        timer_evt_o,
  output logic        busy_o
);
  import cluster_periph_pkg::*;

  timer_reg_e reg_sel;
  logic       wr_en;
  logic       enable_q;
  data_t      count_q;
  data_t      cmp_q;
  logic       match;

  assign reg_sel = timer_reg_e'(bus.offset);
  assign wr_en   = bus.req && bus.we;
  assign match   = enable_q && (count_q == cmp_q);

  // config and compare registers
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      enable_q <= 1'b0;
      cmp_q    <= '0;
    end else if (wr_en) begin
      if (reg_sel == TIMER_CFG) begin
        enable_q <= bus.wdata[0];
      end
      if (reg_sel == TIMER_CMP) begin
        cmp_q <= bus.wdata;
      end
    end
  end

  // bus write to the count wins over the increment
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q <= '0;
    end else if (wr_en && (reg_sel == TIMER_COUNT)) begin
      count_q <= bus.wdata;
    end else if (match) begin
      count_q <= '0;
    end else if (enable_q) begin
      count_q <= count_q + 1'b1;
    end
  end

  always_comb begin
    case (reg_sel)
      TIMER_CFG:   bus.rdata = {{(`DATA_WIDTH-1){1'b0}}, enable_q};
      TIMER_COUNT: bus.rdata = count_q;
      TIMER_CMP:   bus.rdata = cmp_q;
      default:     bus.rdata = '0;
    endcase
  end

  assign timer_evt_o = match;
  assign busy_o      = enable_q;

endmodule

// File: event_buffer.sv
// per-core event buffer and mask
// buffer bits: 0 timer, 1 dma, 2 accelerator, 3 software
// offset bits 5:2 pick the core and 1:0 the register, bits 7:6 are ignored
// core blocks past NB_CORES read zero and drop writes
`timescale 1ns/1ps
`include "cluster_periph_defs.svh"

module event_buffer (
  input  logic                            clk_i,
  input  logic                            reset_i,
  periph_bus_if.slave                     bus,
  input  logic                            timer_evt_i,
  input  logic                            dma_evt_i,
  input  cluster_periph_pkg::core_mask_t  hwpe_evt_i,
  output cluster_periph_pkg::core_mask_t  wait_req_o,
  output cluster_periph_pkg::core_mask_t  pending_o
);
  import cluster_periph_pkg::*;

  logic [3:0]                 core_idx;
  eu_reg_e                    reg_sel;
  logic                       wr_en;
  core_mask_t                 core_sel;
  logic                       sw_wr;
  evt_vec_t [`NB_CORES-1:0]   buffer_q;
  evt_vec_t [`NB_CORES-1:0]   mask_q;
  evt_vec_t [`NB_CORES-1:0]   evt_set;
  evt_vec_t [`NB_CORES-1:0]   evt_clr;

  assign core_idx = bus.offset[5:2];
  assign reg_sel  = eu_reg_e'(bus.offset[1:0]);
  assign wr_en    = bus.req && bus.we;

  // a software event through any valid core block reaches all cores in wdata
  assign sw_wr = wr_en && (reg_sel == EU_SW_EVT) && (|core_sel);

  always_comb begin
    for (int c = 0; c < `NB_CORES; c++) begin
      core_sel[c]   = (core_idx == c);
      evt_set[c]    = {sw_wr && bus.wdata[c], hwpe_evt_i[c], dma_evt_i, timer_evt_i};
      evt_clr[c]    = '0;
      wait_req_o[c] = wr_en && core_sel[c] && (reg_sel == EU_WAIT);
      pending_o[c]  = |(buffer_q[c] & mask_q[c]);
      if (wr_en && core_sel[c] && (reg_sel == EU_BUFFER)) begin
        evt_clr[c] = bus.wdata[`EVT_WIDTH-1:0];
      end
    end
  end

  // set after clear so a new event survives a clear in the same cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      buffer_q <= '0;
      mask_q   <= '0;
    end else begin
      for (int c = 0; c < `NB_CORES; c++) begin
        buffer_q[c] <= (buffer_q[c] & ~evt_clr[c]) | evt_set[c];
        if (wr_en && core_sel[c] && (reg_sel == EU_MASK)) begin
          mask_q[c] <= bus.wdata[`EVT_WIDTH-1:0];
        end
      end
    end
  end

  always_comb begin
    bus.rdata = '0;
    for (int c = 0; c < `NB_CORES; c++) begin
      if (core_sel[c] && (reg_sel == EU_MASK)) begin
        bus.rdata = {{(`DATA_WIDTH-`EVT_WIDTH){1'b0}}, mask_q[c]};
      end
      if (core_sel[c] && (reg_sel == EU_BUFFER)) begin
        bus.rdata = {{(`DATA_WIDTH-`EVT_WIDTH){1'b0}}, buffer_q[c]};
      end
    end
  end

endmodule

// File: core_sleep_fsm.sv
// one run/sleep FSM per core, clock enable is high while running
// a wait with an event already pending does not put the core to sleep
`timescale 1ns/1ps
`include "cluster_periph_defs.svh"

module core_sleep_fsm (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  cluster_periph_pkg::core_mask_t  wait_req_i,
  input  cluster_periph_pkg::core_mask_t  pending_i,
  output cluster_periph_pkg::core_mask_t  core_clk_en_o
);
  import cluster_periph_pkg::*;

  sleep_state_e state_q [`NB_CORES];
  sleep_state_e state_d [`NB_CORES];

  always_comb begin
    for (int c = 0; c < `NB_CORES; c++) begin
      state_d[c] = state_q[c];
      case (state_q[c])
        ST_RUN:   if (wait_req_i[c] && !pending_i[c]) state_d[c] = ST_SLEEP;
        ST_SLEEP: if (pending_i[c]) state_d[c] = ST_RUN;
        default:  state_d[c] = ST_RUN;
      endcase
      core_clk_en_o[c] = (state_q[c] == ST_RUN);
    end
  end

  always_ff @(posedge clk_i) begin
    for (int c = 0; c < `NB_CORES; c++) begin
      if (reset_i) begin
        state_q[c] <= ST_RUN;
      end else begin
        state_q[c] <= state_d[c];
      end
    end
  end

endmodule

// File: cluster_periph_top.sv
// cluster peripheral block: control unit, timer and event unit on one port
// every request is accepted in its cycle and answered one cycle later
// the timer counts on clk_i, there is no separate reference clock
`timescale 1ns/1ps
`include "cluster_periph_defs.svh"

module cluster_periph_top (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            req_i,
  input  logic                            we_i,
  input  logic [`ADDR_WIDTH-1:0]          addr_i,
  input  cluster_periph_pkg::data_t       wdata_i,
  output cluster_periph_pkg::data_t       rdata_o,
  output logic                            rvalid_o,
  input  logic                            dma_evt_i,
  input  cluster_periph_pkg::core_mask_t  hwpe_evt_i,
  output logic                            eoc_o,
  output cluster_periph_pkg::core_mask_t  fetch_en_o,
  output cluster_periph_pkg::data_t       boot_addr_o,
  output logic                            busy_o,
  output cluster_periph_pkg::core_mask_t  core_clk_en_o
);

  logic                           timer_evt;
  cluster_periph_pkg::core_mask_t wait_req;
  cluster_periph_pkg::core_mask_t pending;

  periph_bus_if ctrl_bus ();
  periph_bus_if timer_bus ();
  periph_bus_if eu_bus ();

  //************************************************************
  //******************** address decoder ***********************
  //************************************************************
  periph_decoder i_decoder (
    .clk_i     ( clk_i     ),
    .reset_i   ( reset_i   ),
    .req_i     ( req_i     ),
    .we_i      ( we_i      ),
    .addr_i    ( addr_i    ),
    .wdata_i   ( wdata_i   ),
    .rdata_o   ( rdata_o   ),
    .rvalid_o  ( rvalid_o  ),
    .ctrl_bus  ( ctrl_bus  ),
    .timer_bus ( timer_bus ),
    .eu_bus    ( eu_bus    )
  );

  //************************************************************
  //******************** control unit and timer ****************
  //************************************************************
  cluster_ctrl_regs i_ctrl_regs (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .bus         ( ctrl_bus    ),
    .eoc_o       ( eoc_o       ),
    .fetch_en_o  ( fetch_en_o  ),
    .boot_addr_o ( boot_addr_o )
  );

  cluster_timer i_timer (
    .clk_i       ( clk_i     ),
    .reset_i     ( reset_i   ),
    .bus         ( timer_bus ),
    .timer_evt_o ( timer_evt ),
    .busy_o      ( busy_o    )
  );

  //************************************************************
  //******************** event unit ****************************
  //************************************************************
  event_buffer i_event_buffer (
    .clk_i       ( clk_i      ),
    .reset_i     ( reset_i    ),
    .bus         ( eu_bus     ),
    .timer_evt_i ( timer_evt  ),
    .dma_evt_i   ( dma_evt_i  ),
    .hwpe_evt_i  ( hwpe_evt_i ),
    .wait_req_o  ( wait_req   ),
    .pending_o   ( pending    )
  );

  core_sleep_fsm i_sleep_fsm (
    .clk_i         ( clk_i         ),
    .reset_i       ( reset_i       ),
    .wait_req_i    ( wait_req      ),
    .pending_i     ( pending       ),
    .core_clk_en_o ( core_clk_en_o )
  );

endmodule

// File: cluster_periph_properties.sv
// bus handshake, end-of-computation and timer reset checks of the top level
// attached to cluster_periph_top by the bind below the module
`timescale 1ns/1ps
`include "cluster_periph_defs.svh"

module cluster_periph_properties (
  input logic                      clk_i,
  input logic                      reset_i,
  input logic                      req_i,
  input logic                      we_i,
  input logic [`ADDR_WIDTH-1:0]    addr_i,
  input cluster_periph_pkg::data_t wdata_i,
  input logic                      rvalid_o,
  input logic                      eoc_o,
  input logic                      busy_o
);

  logic eoc_clear;

  // write of zero to the EOC register, byte address 0
  assign eoc_clear = req_i && we_i && (addr_i[`ADDR_WIDTH-1:2] == '0) && !wdata_i[0];

  rvalid_after_req: assert property (@(posedge clk_i) disable iff (reset_i)
    req_i |=> rvalid_o)
    else $error("rvalid_o missing one cycle after req_i");

  rvalid_only_after_req: assert property (@(posedge clk_i) disable iff (reset_i)
    !req_i |=> !rvalid_o)
    else $error("rvalid_o high without a request in the previous cycle");

  eoc_sticky: assert property (@(posedge clk_i) disable iff (reset_i)
    (eoc_o && !eoc_clear) |=> eoc_o)
    else $error("eoc_o dropped without a clear write");

  busy_low_after_reset: assert property (@(posedge clk_i)
    reset_i |=> !busy_o)
    else $error("busy_o high in the cycle after reset");

endmodule

bind cluster_periph_top cluster_periph_properties i_properties (
  .clk_i    ( clk_i    ),
  .reset_i  ( reset_i  ),
  .req_i    ( req_i    ),
  .we_i     ( we_i     ),
  .addr_i   ( addr_i   ),
  .wdata_i  ( wdata_i  ),
  .rvalid_o ( rvalid_o ),
  .eoc_o    ( eoc_o    ),
  .busy_o   ( busy_o   )
);

// File: tb_cluster_periph.sv
// testbench for the cluster peripheral block
// commands and expected values come from cluster_periph_tests.txt as three hex words
// inputs change and outputs are sampled on the falling edge
// the event unit addresses assume NB_CORES is 4
`timescale 1ns/1ps
`include "cluster_periph_defs.svh"

module tb_cluster_periph;
  import cluster_periph_pkg::*;

  localparam int CLK_PERIOD        = 4;
  localparam int RESET_CYCLES      = 8;
  localparam int MAX_WORDS         = 768;
  localparam int WD_CYCLES_PER_CMD = 64;

  // command codes of the tests file
  localparam logic [31:0] CMD_END      = 32'd0;
  localparam logic [31:0] CMD_WRITE    = 32'd1;
  localparam logic [31:0] CMD_READ     = 32'd2;
  localparam logic [31:0] CMD_PULSE    = 32'd3;
  localparam logic [31:0] CMD_IDLE     = 32'd4;
  localparam logic [31:0] CMD_CHECK    = 32'd5;
  localparam logic [31:0] CMD_READ_MAX = 32'd6;

  logic                   clk_i;
  logic                   reset_i;
  logic                   req_i;
  logic                   we_i;
  logic [`ADDR_WIDTH-1:0] addr_i;
  data_t                  wdata_i;
  data_t                  rdata_o;
  logic                   rvalid_o;
  logic                   dma_evt_i;
  core_mask_t             hwpe_evt_i;
  logic                   eoc_o;
  core_mask_t             fetch_en_o;
  data_t                  boot_addr_o;
  logic                   busy_o;
  core_mask_t             core_clk_en_o;

  logic [31:0] tests_mem [MAX_WORDS];
  int          num_cmds;
  int          check_errors;
  int          protocol_errors;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  cluster_periph_top i_dut (
    .clk_i         ( clk_i         ),
    .reset_i       ( reset_i       ),
    .req_i         ( req_i         ),
    .we_i          ( we_i          ),
    .addr_i        ( addr_i        ),
    .wdata_i       ( wdata_i       ),
    .rdata_o       ( rdata_o       ),
    .rvalid_o      ( rvalid_o      ),
    .dma_evt_i     ( dma_evt_i     ),
    .hwpe_evt_i    ( hwpe_evt_i    ),
    .eoc_o         ( eoc_o         ),
    .fetch_en_o    ( fetch_en_o    ),
    .boot_addr_o   ( boot_addr_o   ),
    .busy_o        ( busy_o        ),
    .core_clk_en_o ( core_clk_en_o )
  );

  //************************************************************
  //******************** compare tasks *************************
  //************************************************************
  task automatic check_word(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
      check_errors++;
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_mask(input core_mask_t got, input core_mask_t exp, input string what);
    if (got !== exp) begin
      check_errors++;
      $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // upper bound check for a value that keeps moving like the timer count
  task automatic check_limit(input data_t got, input data_t lim, input string what);
    if ($isunknown(got) || got > lim) begin
      check_errors++;
      $display("CHECK FAILED at %0t ns: %s got %h above limit %h", $time, what, got, lim);
    end
  endtask

  //************************************************************
  //******************** bus and event drivers *****************
  //************************************************************
  // starts at a falling edge and returns at the falling edge of the response cycle
  task automatic bus_access(input logic write, input logic [`ADDR_WIDTH-1:0] addr,
                            input data_t data, output data_t rdata);
    req_i   = 1'b1;
    we_i    = write;
    addr_i  = addr;
    wdata_i = data;
    @(negedge clk_i);
    req_i   = 1'b0;
    we_i    = 1'b0;
    wdata_i = '0;
    rdata   = rdata_o;
    if (rvalid_o !== 1'b1) begin
      protocol_errors++;
      $display("no rvalid_o one cycle after the request to address %h at %0t ns", addr, $time);
    end
  endtask

  task automatic pulse_events(input core_mask_t hwpe, input logic dma);
    hwpe_evt_i = hwpe;
    dma_evt_i  = dma;
    @(negedge clk_i);
    hwpe_evt_i = '0;
    dma_evt_i  = 1'b0;
  endtask

  task automatic check_outputs(input logic [31:0] sel, input data_t exp);
    case (sel)
      32'd0:   check_word(data_t'(eoc_o), exp, "eoc_o");
      32'd1:   check_mask(fetch_en_o, core_mask_t'(exp), "fetch_en_o");
      32'd2:   check_word(boot_addr_o, exp, "boot_addr_o");
      32'd3:   check_word(data_t'(busy_o), exp, "busy_o");
      32'd4:   check_mask(core_clk_en_o, core_mask_t'(exp), "core_clk_en_o");
      default: begin
        protocol_errors++;
        $display("tests file names an unknown output selector %0d", sel);
      end
    endcase
  endtask

  // number of commands up to the end marker
  function automatic int count_commands();
    int n;
    n = 0;
    while ((3 * n + 2 < MAX_WORDS) && (tests_mem[3 * n] != CMD_END)) begin
      n++;
    end
    return n;
  endfunction

  //************************************************************
  //******************** command sequencer *********************
  //************************************************************
  initial begin : run_tests
    data_t       rd;
    logic [31:0] cmd;
    logic [31:0] arg_a;
    logic [31:0] arg_b;
    clk_i           = 1'b0;
    reset_i         = 1'b1;
    req_i           = 1'b0;
    we_i            = 1'b0;
    addr_i          = '0;
    wdata_i         = '0;
    dma_evt_i       = 1'b0;
    hwpe_evt_i      = '0;
    check_errors    = 0;
    protocol_errors = 0;
    for (int i = 0; i < MAX_WORDS; i++) begin
      tests_mem[i] = '0;
    end
    $readmemh("cluster_periph_tests.txt", tests_mem);
    num_cmds = count_commands();
    if (num_cmds == 0) begin
      protocol_errors++;
      $display("tests file cluster_periph_tests.txt held no commands");
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    for (int n = 0; n < num_cmds; n++) begin
      cmd   = tests_mem[3 * n];
      arg_a = tests_mem[3 * n + 1];
      arg_b = tests_mem[3 * n + 2];
      case (cmd)
        CMD_WRITE: begin
          bus_access(1'b1, arg_a[`ADDR_WIDTH-1:0], arg_b, rd);
          // write responses carry no data
          check_word(rd, '0, $sformatf("write response of %h", arg_a[`ADDR_WIDTH-1:0]));
        end
        CMD_READ: begin
          bus_access(1'b0, arg_a[`ADDR_WIDTH-1:0], '0, rd);
          check_word(rd, arg_b, $sformatf("read of %h", arg_a[`ADDR_WIDTH-1:0]));
        end
        CMD_READ_MAX: begin
          bus_access(1'b0, arg_a[`ADDR_WIDTH-1:0], '0, rd);
          check_limit(rd, arg_b, $sformatf("read of %h", arg_a[`ADDR_WIDTH-1:0]));
        end
        CMD_PULSE: pulse_events(arg_a[`NB_CORES-1:0], arg_b[0]);
        CMD_IDLE:  repeat (arg_b) @(negedge clk_i);
        CMD_CHECK: check_outputs(arg_a, arg_b);
        default: begin
          protocol_errors++;
          $display("tests file command %0d has unknown code %0d", n, cmd);
        end
      endcase
    end
    $display("closing: %0d check errors, %0d protocol errors", check_errors, protocol_errors);
    if (check_errors == 0 && protocol_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // run length is bounded by the number of commands
  initial begin : watchdog
    wait (num_cmds > 0);
    #((num_cmds * WD_CYCLES_PER_CMD + 2 * RESET_CYCLES) * CLK_PERIOD);
    $display("watchdog expired after %0d commands, the run did not finish", num_cmds);
    $display("** FAIL **");
    $finish;
  end

endmodule

// File: cluster_periph_tests.txt
// columns: command, address or selector or hwpe mask, data or expected value (all hex)
// 1 write, 2 read and expect, 3 pulse events (hwpe mask, dma), 4 idle, 5 check output, 6 read at most, 0 end
// check selectors: 0 eoc, 1 fetch_en, 2 boot_addr, 3 busy, 4 core_clk_en
5 2 1C000000
2 008 1C000000
5 4 F
5 3 0
1 004 5
1 008 1C008000
5 1 5
5 2 1C008000
2 004 5
2 008 1C008000
1 000 1
5 0 1
2 000 1
2 C04 0
1 C08 DEADBEEF
2 C08 0
2 008 1C008000
5 1 5
1 408 3
1 400 1
4 0 10
5 3 1
2 804 1
2 814 1
2 824 1
2 834 1
6 404 3
1 400 0
1 804 F
1 814 F
1 824 F
1 834 F
2 804 0
3 0 1
3 4 0
1 80C 9
2 804 A
2 814 2
2 824 6
2 834 A
1 824 2
2 824 4
1 804 F
1 814 F
1 824 F
1 834 F
1 810 4
2 810 4
1 818 0
5 4 D
3 0 1
4 0 2
5 4 D
3 2 0
5 4 D
4 0 1
5 4 F
2 804 2
1 800 2
1 808 0
5 4 F
4 0 2
5 4 F
0 0 0

// File: project.f
+incdir+.
cluster_periph_pkg.sv
periph_bus_if.sv
periph_decoder.sv
cluster_ctrl_regs.sv
cluster_timer.sv
event_buffer.sv
core_sleep_fsm.sv
cluster_periph_top.sv
cluster_periph_properties.sv
tb_cluster_periph.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the cluster peripheral testbench with Verilator and runs it
# the result is taken from the pass line in sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal -f project.f --top-module tb_cluster_periph \
  -o sim_cluster_periph \
  && ./obj_dir/sim_cluster_periph > sim.log 2>&1 \
  || echo "build or simulation ended with an error"

grep -sqxF '** PASS **' sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
